//--- hw/shade_cfg.svh
`ifndef SHADE_CFG_SVH
`define SHADE_CFG_SVH

// signed vertex coordinate width
`define SHADE_COORD_W 10

// greyscale output width
`define SHADE_COLOR_W 8

// number of table steps and the scale applied to cos^2
`define SHADE_LUT_STEPS 16

// normal facing away from the viewer
`define SHADE_BACKFACE_COLOR 255

// collinear vertices give no usable normal
`define SHADE_DEGENERATE_COLOR 0

`endif

//--- hw/shade_pkg.sv
`include "shade_cfg.svh"

package shade_pkg;

    localparam int COORD_W = `SHADE_COORD_W;
    // difference of two coordinates needs one more bit
    localparam int EDGE_W  = COORD_W + 1;
    // product of two edges plus the sign of a difference
    localparam int CROSS_W = 2 * EDGE_W + 1;
    // sum of three squares with headroom for the x16 scale
    localparam int MAG_W   = 2 * CROSS_W + 2;
    localparam int INDEX_W = $clog2(`SHADE_LUT_STEPS);
    localparam int COLOR_W = `SHADE_COLOR_W;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef logic signed [EDGE_W-1:0] edge_t;

    typedef logic signed [CROSS_W-1:0] cross_t;

    // face normal whose nz sign tells front from back
    typedef struct packed {
        cross_t nx;
        cross_t ny;
        cross_t nz;
    } normal_t;

    typedef logic [MAG_W-1:0] mag_t;

    typedef logic [INDEX_W-1:0] lut_index_t;

    typedef logic [COLOR_W-1:0] color_t;

endpackage

//--- hw/shade_if.sv
`timescale 1ns/1ps

// face normal from the cross product stage to the divider
interface normal_if;

    shade_pkg::normal_t normal;
    logic               valid;
    logic               ready;

    modport source (output normal, output valid, input ready);
    modport sink (input normal, input valid, output ready);

endinterface

// table index plus override flags from the divider to the tone map
interface shade_if;

    shade_pkg::lut_index_t index;
    logic                  backface;
    logic                  zero_normal;
    logic                  valid;
    logic                  ready;

    modport source (
        output index,
        output backface,
        output zero_normal,
        output valid,
        input  ready
    );

    modport sink (
        input  index,
        input  backface,
        input  zero_normal,
        input  valid,
        output ready
    );

endinterface

//--- hw/face_normal.sv
`timescale 1ns/1ps

module face_normal (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               triangle_req,
    input  shade_pkg::vertex_t v0,
    input  shade_pkg::vertex_t v1,
    input  shade_pkg::vertex_t v2,
    output logic               triangle_ack,
    normal_if.source           out
);

    // edge vectors v1-v0 and v2-v0
    shade_pkg::edge_t e1x;
    shade_pkg::edge_t e1y;
    shade_pkg::edge_t e1z;
    shade_pkg::edge_t e2x;
    shade_pkg::edge_t e2y;
    shade_pkg::edge_t e2z;
    logic             edge_valid;

    logic               edge_advance;
    logic               edge_free;
    logic               take;
    shade_pkg::normal_t normal_next;

    // normal register is free when empty or when the divider takes it now
    assign edge_advance = edge_valid && (!out.valid || out.ready);
    assign edge_free    = !edge_valid || edge_advance;

    // ack low means the previous four-phase cycle is closed
    assign take = triangle_req && !triangle_ack && edge_free;

    // intake side of the four-phase handshake
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            triangle_ack <= 1'b0;
        end else if (take) begin
            triangle_ack <= 1'b1;
        end else if (!triangle_req) begin
            triangle_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            edge_valid <= 1'b0;
        end else if (take) begin
            edge_valid <= 1'b1;
        end else if (edge_advance) begin
            edge_valid <= 1'b0;
        end
    end

    // vertices are only sampled here and the sender may change them after ack
    always_ff @(posedge clk_in) begin
        if (take) begin
            e1x <= shade_pkg::edge_t'(v1.x) - shade_pkg::edge_t'(v0.x);
            e1y <= shade_pkg::edge_t'(v1.y) - shade_pkg::edge_t'(v0.y);
            e1z <= shade_pkg::edge_t'(v1.z) - shade_pkg::edge_t'(v0.z);
            e2x <= shade_pkg::edge_t'(v2.x) - shade_pkg::edge_t'(v0.x);
            e2y <= shade_pkg::edge_t'(v2.y) - shade_pkg::edge_t'(v0.y);
            e2z <= shade_pkg::edge_t'(v2.z) - shade_pkg::edge_t'(v0.z);
        end
    end

    // cross product e1 x e2 with operands widened before the multiply
    always_comb begin
        normal_next.nx = shade_pkg::cross_t'(e1y) * shade_pkg::cross_t'(e2z)
                       - shade_pkg::cross_t'(e1z) * shade_pkg::cross_t'(e2y);
        normal_next.ny = shade_pkg::cross_t'(e1z) * shade_pkg::cross_t'(e2x)
                       - shade_pkg::cross_t'(e1x) * shade_pkg::cross_t'(e2z);
        normal_next.nz = shade_pkg::cross_t'(e1x) * shade_pkg::cross_t'(e2y)
                       - shade_pkg::cross_t'(e1y) * shade_pkg::cross_t'(e2x);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            out.valid <= 1'b0;
        end else if (edge_advance) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (edge_advance) begin
            out.normal <= normal_next;
        end
    end

endmodule

//--- hw/cos_sq_divider.sv
`timescale 1ns/1ps
`include "shade_cfg.svh"

module cos_sq_divider (
    input logic     clk_in,
    input logic     rst_in,
    normal_if.sink  in,
    shade_if.source out
);

    // quotient runs 0..16 and needs one bit more than the index
    localparam int DIV_STEPS = $clog2(`SHADE_LUT_STEPS) + 1;
    localparam int STEP_W    = $clog2(DIV_STEPS);
    localparam int SCALE_SH  = $clog2(`SHADE_LUT_STEPS);
    localparam int LUT_MAX   = `SHADE_LUT_STEPS - 1;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        HOLD
    } state_t;

    state_t state;

    // components sign-extended so the squares keep their full width
    logic signed [shade_pkg::MAG_W-1:0] nx_w;
    logic signed [shade_pkg::MAG_W-1:0] ny_w;
    logic signed [shade_pkg::MAG_W-1:0] nz_w;
    shade_pkg::mag_t                    mag_sum;
    shade_pkg::mag_t                    num_scaled;

    shade_pkg::mag_t      rem;
    shade_pkg::mag_t      dsr;
    logic [DIV_STEPS-1:0] quo;
    logic [STEP_W-1:0]    step;
    logic                 take;

    assign nx_w = in.normal.nx;
    assign ny_w = in.normal.ny;
    assign nz_w = in.normal.nz;

    // |n|^2 and 16*nz^2 are both non-negative
    assign mag_sum    = shade_pkg::mag_t'(nx_w * nx_w + ny_w * ny_w + nz_w * nz_w);
    assign num_scaled = shade_pkg::mag_t'(nz_w * nz_w) << SCALE_SH;

    assign in.ready  = (state == IDLE);
    assign out.valid = (state == HOLD);
    assign take      = in.valid && in.ready;

    // a normal parallel to z gives exactly 16 and clamps to the last entry
    assign out.index = (quo > LUT_MAX) ? shade_pkg::lut_index_t'(LUT_MAX)
                                       : shade_pkg::lut_index_t'(quo);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (in.valid) begin
                        step <= '0;
                        // nothing to divide for a zero normal
                        if (mag_sum == '0) begin
                            state <= HOLD;
                        end else begin
                            state <= DIVIDE;
                        end
                    end
                end
                DIVIDE: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(DIV_STEPS - 1)) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (out.ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // restoring division with the divisor starting at mag*16 and halving each step
    always_ff @(posedge clk_in) begin
        if (take) begin
            rem             <= num_scaled;
            dsr             <= mag_sum << SCALE_SH;
            quo             <= '0;
            out.backface    <= in.normal.nz[shade_pkg::CROSS_W-1];
            out.zero_normal <= (mag_sum == '0);
        end else if (state == DIVIDE) begin
            if (rem >= dsr) begin
                rem <= rem - dsr;
                quo <= {quo[DIV_STEPS-2:0], 1'b1};
            end else begin
                quo <= {quo[DIV_STEPS-2:0], 1'b0};
            end
            dsr <= dsr >> 1;
        end
    end

endmodule

//--- hw/tone_map.sv
`timescale 1ns/1ps
`include "shade_cfg.svh"

module tone_map (
    input  logic              clk_in,
    input  logic              rst_in,
    shade_if.sink             in,
    output shade_pkg::color_t color,
    output logic              color_req,
    input  logic              color_ack
);

    // set for the one cycle between accept and color_req
    logic              pend;
    shade_pkg::color_t shade;

    // light falls off faster near grazing angles
    function automatic shade_pkg::color_t grey_level(input shade_pkg::lut_index_t idx);
        case (idx)
            4'd0:    grey_level = 8'd0;
            4'd1:    grey_level = 8'd20;
            4'd2:    grey_level = 8'd40;
            4'd3:    grey_level = 8'd60;
            4'd4:    grey_level = 8'd78;
            4'd5:    grey_level = 8'd96;
            4'd6:    grey_level = 8'd114;
            4'd7:    grey_level = 8'd130;
            4'd8:    grey_level = 8'd146;
            4'd9:    grey_level = 8'd162;
            4'd10:   grey_level = 8'd178;
            4'd11:   grey_level = 8'd194;
            4'd12:   grey_level = 8'd210;
            4'd13:   grey_level = 8'd226;
            4'd14:   grey_level = 8'd242;
            // top step saturates at full scale
            default: grey_level = 8'd255;
        endcase
    endfunction

    // degenerate wins over back face
    always_comb begin
        if (in.zero_normal) begin
            shade = shade_pkg::color_t'(`SHADE_DEGENERATE_COLOR);
        end else if (in.backface) begin
            shade = shade_pkg::color_t'(`SHADE_BACKFACE_COLOR);
        end else begin
            shade = grey_level(in.index);
        end
    end

    // take a new result only once the receiver has dropped its ack
    assign in.ready = !pend && !color_req && !color_ack;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pend      <= 1'b0;
            color_req <= 1'b0;
        end else if (in.valid && in.ready) begin
            pend <= 1'b1;
        end else if (pend) begin
            pend      <= 1'b0;
            color_req <= 1'b1;
        end else if (color_req && color_ack) begin
            color_req <= 1'b0;
        end
    end

    // color only changes on accept and stays stable while req is high
    always_ff @(posedge clk_in) begin
        if (in.valid && in.ready) begin
            color <= shade;
        end
    end

endmodule

//--- hw/pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader (
    input  logic               clk_in,
    input  logic               rst_in,

    // four-phase triangle intake
    input  logic               triangle_req,
    input  shade_pkg::vertex_t v0,
    input  shade_pkg::vertex_t v1,
    input  shade_pkg::vertex_t v2,
    output logic               triangle_ack,

    // four-phase color output
    output shade_pkg::color_t  color,
    output logic               color_req,
    input  logic               color_ack
);

    normal_if normal_link ();
    shade_if  shade_link ();

    // edges and cross product
    face_normal u_face_normal (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .triangle_req (triangle_req),
        .v0           (v0),
        .v1           (v1),
        .v2           (v2),
        .triangle_ack (triangle_ack),
        .out          (normal_link.source)
    );

    // cos^2 to table index with variable latency
    cos_sq_divider u_cos_sq_divider (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .in     (normal_link.sink),
        .out    (shade_link.source)
    );

    // table lookup and output handshake
    tone_map u_tone_map (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in        (shade_link.sink),
        .color     (color),
        .color_req (color_req),
        .color_ack (color_ack)
    );

endmodule

//--- tb/tb_pixel_shader.sv
`timescale 1ns/1ps
`include "shade_cfg.svh"

module tb_pixel_shader;

    localparam int NUM_RANDOM = 200;
    // four directed triangles ahead of the random ones
    localparam int NUM_TOTAL  = NUM_RANDOM + 4;
    localparam int TIMEOUT    = 2000;

    localparam shade_pkg::color_t GREY [16] = '{
        8'd0, 8'd20, 8'd40, 8'd60, 8'd78, 8'd96, 8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194, 8'd210, 8'd226, 8'd242, 8'd255
    };

    logic               clk_in;
    logic               rst_in;
    logic               triangle_req;
    shade_pkg::vertex_t v0;
    shade_pkg::vertex_t v1;
    shade_pkg::vertex_t v2;
    logic               triangle_ack;
    shade_pkg::color_t  color;
    logic               color_req;
    logic               color_ack;

    logic [31:0]        rng;
    int                 ack_delay [NUM_TOTAL];
    shade_pkg::color_t  expected_q [$];
    int                 req_rises;
    logic               req_seen;

    pixel_shader dut0 (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .triangle_req (triangle_req),
        .v0           (v0),
        .v1           (v1),
        .v2           (v2),
        .triangle_ack (triangle_ack),
        .color        (color),
        .color_req    (color_req),
        .color_ack    (color_ack)
    );

    always #20 clk_in = ~clk_in;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic shade_pkg::vertex_t random_vertex(input logic [31:0] r);
        shade_pkg::vertex_t v;
        v.x = r[9:0];
        v.y = r[19:10];
        v.z = r[29:20];
        return v;
    endfunction

    // exact integer reference for the flat shading rule
    function automatic shade_pkg::color_t expected_color(input shade_pkg::vertex_t a,
                                                         input shade_pkg::vertex_t b,
                                                         input shade_pkg::vertex_t c);
        longint e1x;
        longint e1y;
        longint e1z;
        longint e2x;
        longint e2y;
        longint e2z;
        longint nx;
        longint ny;
        longint nz;
        longint mag;
        longint q;
        e1x = longint'(b.x) - longint'(a.x);
        e1y = longint'(b.y) - longint'(a.y);
        e1z = longint'(b.z) - longint'(a.z);
        e2x = longint'(c.x) - longint'(a.x);
        e2y = longint'(c.y) - longint'(a.y);
        e2z = longint'(c.z) - longint'(a.z);
        nx  = e1y * e2z - e1z * e2y;
        ny  = e1z * e2x - e1x * e2z;
        nz  = e1x * e2y - e1y * e2x;
        mag = nx * nx + ny * ny + nz * nz;
        if (mag == 0) begin
            return `SHADE_DEGENERATE_COLOR;
        end
        if (nz < 0) begin
            return `SHADE_BACKFACE_COLOR;
        end
        q = (`SHADE_LUT_STEPS * nz * nz) / mag;
        if (q > `SHADE_LUT_STEPS - 1) begin
            q = `SHADE_LUT_STEPS - 1;
        end
        return GREY[q];
    endfunction

    task automatic wait_triangle_ack(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_in);
            cycles++;
            assert (cycles <= TIMEOUT)
                else report_failure("timeout waiting for triangle_ack to change");
        end while (triangle_ack !== level);
    endtask

    task automatic wait_color_req(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_in);
            cycles++;
            assert (cycles <= TIMEOUT)
                else report_failure("timeout waiting for color_req to change");
        end while (color_req !== level);
    endtask

    // one four-phase cycle on the intake side with the vertices held while req is high
    task automatic send_triangle(input shade_pkg::vertex_t a, input shade_pkg::vertex_t b,
                                 input shade_pkg::vertex_t c, input shade_pkg::color_t exp);
        @(posedge clk_in);
        v0           <= a;
        v1           <= b;
        v2           <= c;
        triangle_req <= 1'b1;
        expected_q.push_back(exp);
        wait_triangle_ack(1'b1);
        triangle_req <= 1'b0;
        wait_triangle_ack(1'b0);
    endtask

    task automatic send_all();
        shade_pkg::vertex_t a;
        shade_pkg::vertex_t b;
        shade_pkg::vertex_t c;
        // flat in xy and counter-clockwise so index 16 clamps to the last entry
        send_triangle('{-10'sd20, -10'sd20, 10'sd7}, '{10'sd30, -10'sd20, 10'sd7},
                      '{-10'sd20, 10'sd40, 10'sd7}, 8'd255);
        // same triangle clockwise faces away
        send_triangle('{-10'sd20, -10'sd20, 10'sd7}, '{-10'sd20, 10'sd40, 10'sd7},
                      '{10'sd30, -10'sd20, 10'sd7}, 8'd255);
        // collinear
        send_triangle('{10'sd1, 10'sd2, 10'sd3}, '{10'sd3, 10'sd6, 10'sd9},
                      '{-10'sd2, -10'sd4, -10'sd6}, 8'd0);
        // normal at 45 degrees where cos^2 = 1/2 gives index 8
        send_triangle('{10'sd0, 10'sd0, 10'sd0}, '{10'sd10, 10'sd0, 10'sd10},
                      '{10'sd0, 10'sd10, 10'sd0}, 8'd146);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng = xorshift32(rng);
            a   = random_vertex(rng);
            rng = xorshift32(rng);
            b   = random_vertex(rng);
            rng = xorshift32(rng);
            c   = random_vertex(rng);
            // now and then a repeated vertex for a degenerate case
            if (i % 16 == 5) begin
                c = a;
            end
            send_triangle(a, b, c, expected_color(a, b, c));
            rng = xorshift32(rng);
            repeat (rng % 8) @(posedge clk_in);
        end
    endtask

    task automatic receive_all();
        shade_pkg::color_t exp;
        for (int n = 0; n < NUM_TOTAL; n++) begin
            wait_color_req(1'b1);
            assert (expected_q.size() > 0)
                else report_failure("color_req raised with no triangle outstanding");
            exp = expected_q.pop_front();
            assert (color == exp)
                else report_failure($sformatf(
                    "Error: color = 0x%02h, expected 0x%02h (result %0d)", color, exp, n));
            // back-pressure on the output side
            repeat (ack_delay[n]) @(posedge clk_in);
            color_ack <= 1'b1;
            wait_color_req(1'b0);
            color_ack <= 1'b0;
        end
    endtask

    // count rising edges of color_req to catch extra results
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            req_seen  <= 1'b0;
            req_rises <= 0;
        end else begin
            req_seen <= color_req;
            if (color_req && !req_seen) begin
                req_rises <= req_rises + 1;
            end
        end
    end

    assert property (@(posedge clk_in) rst_in |=> !triangle_ack && !color_req)
        else report_failure("triangle_ack or color_req high during or right after reset");

    assert property (@(posedge clk_in) disable iff (rst_in)
                     color_req && $past(color_req) |-> $stable(color))
        else report_failure("color changed while color_req was high");

    assert property (@(posedge clk_in) disable iff (rst_in)
                     $rose(color_req) |-> !color_ack && !$past(color_ack))
        else report_failure("color_req rose while color_ack was still high");

    assert property (@(posedge clk_in) disable iff (rst_in)
                     color_req && !color_ack |=> color_req)
        else report_failure("color_req dropped before color_ack was seen");

    assert property (@(posedge clk_in) disable iff (rst_in)
                     $rose(triangle_ack) |-> $past(triangle_req))
        else report_failure("triangle_ack rose without triangle_req");

    assert property (@(posedge clk_in) disable iff (rst_in)
                     $fell(triangle_ack) |-> !$past(triangle_req))
        else report_failure("triangle_ack fell while triangle_req was high");

    assert property (@(posedge clk_in) disable iff (rst_in)
                     triangle_ack && triangle_req |=> triangle_ack)
        else report_failure("triangle_ack dropped before triangle_req went low");

    initial begin
        clk_in       = 1'b0;
        rst_in       = 1'b1;
        triangle_req = 1'b0;
        v0           = '0;
        v1           = '0;
        v2           = '0;
        color_ack    = 1'b0;
        rng          = 32'hbe55_ec40;
        for (int i = 0; i < NUM_TOTAL; i++) begin
            rng          = xorshift32(rng);
            ack_delay[i] = rng % 21;
        end
        repeat (4) @(posedge clk_in);
        rst_in <= 1'b0;
        @(posedge clk_in);
        assert (!triangle_ack && !color_req)
            else report_failure("handshake outputs not low after reset");
        fork
            send_all();
            receive_all();
        join
        // idle time to expose a duplicated result
        repeat (50) @(posedge clk_in);
        if (req_rises == NUM_TOTAL && expected_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_failure($sformatf("Error: req_rises = 0x%0h, expected 0x%0h",
                                     req_rises, NUM_TOTAL));
        end
    end

endmodule

//--- tb.f
+incdir+hw
hw/shade_pkg.sv
hw/shade_if.sv
hw/face_normal.sv
hw/cos_sq_divider.sv
hw/tone_map.sv
hw/pixel_shader.sv
tb/tb_pixel_shader.sv
